// File: src/qmem_pkg.sv
package qmem_pkg;

  // ----------------------------------------
  // Bus and RAM word types
  // ----------------------------------------

  // Byte address as seen on the bus
  typedef logic [15:0] bus_addr_t;
  // Word index into the RAM, byte address bits 13:1
  typedef logic [12:0] word_addr_t;
  // One bus word
  typedef logic [15:0] data_t;
  // Byte lane enables, bit 0 is the low byte
  typedef logic [1:0]  lane_t;

  // ----------------------------------------
  // Window and RAM geometry
  // ----------------------------------------

  localparam int        MEM_WORDS     = 8192;
  // 16 KB window starting at zero
  localparam bus_addr_t WIN_BASE      = 16'h0000;
  // Address bits 15:14 must match this for a hit
  localparam logic [1:0] WIN_TOP_BITS = 2'b00;
  // Preload image, one hex word per line
  localparam string     MEM_INIT_FILE = "mem_init.hex";

  // Bus cycle control states
  typedef enum logic [2:0] {
    IDLE, ADDR, WAIT_STB, ACCESS, REPLY, WAIT_END
  } cyc_state_t;

endpackage

// File: src/mem_if.sv
interface mem_if
  import qmem_pkg::*;
();

  // Word index, held for the whole bus cycle
  word_addr_t addr;
  // Write data, held from the strobe until the cycle ends
  data_t      wdata;
  // One-cycle write request
  logic       we;
  // Lanes to write, valid with we
  lane_t      byteena;
  // Read word from the registered address
  data_t      rdata;

  // Bus side, shared by the latch and the control
  modport host (
    output addr, wdata, we, byteena,
    input  rdata
  );

  // Storage side
  modport ram (
    input  addr, wdata, we, byteena,
    output rdata
  );

endinterface

// File: src/qbus_cycle_ctrl.sv
module qbus_cycle_ctrl
  import qmem_pkg::*;
(
  input  logic clka,
  input  logic rst,
  input  logic sync,
  input  logic din,
  input  logic dout,
  input  logic hit,
  output logic rply,
  output logic addr_load,
  output logic data_load,
  mem_if.host  mem
);

  cyc_state_t state;
  cyc_state_t state_nxt;

  // Previous sync level, for the rising edge
  logic sync_q;
  logic sync_rise;
  // Either strobe, only one is ever high per cycle
  logic stb;

  // ----------------------------------------
  // Edge and strobe decode
  // ----------------------------------------

  assign sync_rise = sync & ~sync_q;
  assign stb       = din | dout;

  // Address is valid on the same edge sync is first seen high
  assign addr_load = (state == IDLE) && sync_rise;

  // Write data captured on the edge the strobe is first seen
  assign data_load = (state == WAIT_STB) && sync && dout;

  // Reply level follows the state directly
  assign rply = (state == REPLY);

  // ----------------------------------------
  // State register and write pulse
  // ----------------------------------------

  always_ff @(posedge clka)
  begin
    if (rst)
    begin
      state  <= IDLE;
      sync_q <= 1'b0;
      mem.we <= 1'b0;
    end
    else
    begin
      state  <= state_nxt;
      sync_q <= sync;
      // High for exactly the ACCESS cycle of a write
      mem.we <= data_load;
    end
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (sync_rise)
          state_nxt = ADDR;
      end
      ADDR:
      begin
        // Latched decode now valid
        if (hit)
          state_nxt = WAIT_STB;
        else
          state_nxt = WAIT_END;
      end
      WAIT_STB:
      begin
        // Master gave up before any strobe
        if (!sync)
          state_nxt = IDLE;
        else if (stb)
          state_nxt = ACCESS;
      end
      ACCESS:
      begin
        // RAM registers address and lanes at the end of this cycle
        state_nxt = REPLY;
      end
      REPLY:
      begin
        // Hold rply while the master stalls on its strobe
        if (!stb)
          state_nxt = WAIT_END;
      end
      WAIT_END:
      begin
        // Out-of-window cycles park here too, never replied
        if (!sync)
          state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

endmodule

// File: src/bus_latch.sv
module bus_latch
  import qmem_pkg::*;
(
  input  logic      clka,
  input  logic      rst,
  input  logic      addr_load,
  input  logic      data_load,
  input  bus_addr_t addr,
  input  data_t     wdata,
  input  logic      wtbt,
  output logic      hit,
  mem_if.host       mem
);

  // Address relative to the window base
  bus_addr_t offset;
  // Odd byte of the addressed word
  logic      odd_byte;
  // Window decode on the live bus address
  logic      in_window;
  // Lane pattern for the pending write
  lane_t     lanes;

  // ----------------------------------------
  // Window decode and lane select
  // ----------------------------------------

  assign offset    = addr - WIN_BASE;
  assign in_window = (addr[15:14] == WIN_TOP_BITS);

  // Byte write picks one lane, word write takes both
  always_comb
  begin
    if (wtbt)
      lanes = odd_byte ? 2'b10 : 2'b01;
    else
      lanes = 2'b11;
  end

  // ----------------------------------------
  // Cycle-long registers
  // ----------------------------------------

  // Hit and lanes are control state
  always_ff @(posedge clka)
  begin
    if (rst)
    begin
      hit         <= 1'b0;
      mem.byteena <= 2'b00;
    end
    else
    begin
      if (addr_load)
        hit <= in_window;
      if (data_load)
        mem.byteena <= lanes;
    end
  end

  // Address and data payload
  always_ff @(posedge clka)
  begin
    if (addr_load)
    begin
      mem.addr <= offset[13:1];
      odd_byte <= addr[0];
    end
    // Byte data already sits on its own lane
    if (data_load)
      mem.wdata <= wdata;
  end

endmodule

// File: src/word_ram.sv
module word_ram
  import qmem_pkg::*;
(
  input logic clka,
  mem_if.ram  mem
);

  data_t      ram [MEM_WORDS];
  // Registered word address, drives both ports
  word_addr_t areg;
  // Lane write enables, one cycle behind we
  lane_t      wreg;

  // ----------------------------------------
  // Registered address, delayed byte write
  // ----------------------------------------

  always_ff @(posedge clka)
  begin
    areg <= mem.addr;
    wreg <= mem.byteena & {2{mem.we}};

    // Write lands one edge after we, data still held by the latch
    for (int i = 0; i < 2; i++)
    begin
      if (wreg[i])
        ram[areg][i*8 +: 8] <= mem.wdata[i*8 +: 8];
    end
  end

  // Read is straight off the registered address
  assign mem.rdata = ram[areg];

  // Boot image, inferred block RAM keeps the contents
  initial
  begin
    $readmemh(MEM_INIT_FILE, ram);
  end

endmodule

// File: src/qbus_mem_top.sv
module qbus_mem_top
  import qmem_pkg::*;
(
  input  logic      clka,
  input  logic      rst,
  input  logic      sync,
  input  logic      din,
  input  logic      dout,
  input  logic      wtbt,
  input  bus_addr_t addr,
  input  data_t     wdata,
  output logic      rply,
  output data_t     rdata
);

  // Window decode back to the control
  logic hit;
  // Latch strobes from the control
  logic addr_load;
  logic data_load;

  // ----------------------------------------
  // RAM port bundle
  // ----------------------------------------

  mem_if mem_bus ();

  // ----------------------------------------
  // Bus cycle sequencing
  // ----------------------------------------

  qbus_cycle_ctrl u_ctrl (
    .clka      (clka),
    .rst       (rst),
    .sync      (sync),
    .din       (din),
    .dout      (dout),
    .hit       (hit),
    .rply      (rply),
    .addr_load (addr_load),
    .data_load (data_load),
    .mem       (mem_bus)
  );

  // Address, data and lane registers
  bus_latch u_latch (
    .clka      (clka),
    .rst       (rst),
    .addr_load (addr_load),
    .data_load (data_load),
    .addr      (addr),
    .wdata     (wdata),
    .wtbt      (wtbt),
    .hit       (hit),
    .mem       (mem_bus)
  );

  // 8K x 16 storage
  word_ram u_ram (
    .clka (clka),
    .mem  (mem_bus)
  );

  // Read word goes straight out, qualified by rply at the master
  assign rdata = mem_bus.rdata;

endmodule

// File: dv/qbus_mem_sva.sv
module qbus_mem_sva
  import qmem_pkg::*;
(
  input logic       clka,
  input logic       rst,
  input logic       sync,
  input logic       din,
  input logic       dout,
  input logic       hit,
  input logic       rply,
  input logic       we,
  input cyc_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far, read by the testbench
  int fail_count = 0;

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------

  // No reply outside a bus cycle
  rply_needs_sync: assert property (@(posedge clka) disable iff (rst)
    $rose(rply) |-> sync)
  else
  begin
    fail_count++;
    $error("rply rose while sync was low");
  end

  // Strobe first seen in a hit cycle, reply two edges later
  rply_latency: assert property (@(posedge clka) disable iff (rst)
    (state == WAIT_STB && hit && sync && (din || dout)) |-> ##2 $rose(rply))
  else
  begin
    fail_count++;
    $error("rply did not rise two cycles after the strobe");
  end

  // Strobe gone, reply released on the next edge
  rply_release: assert property (@(posedge clka) disable iff (rst)
    (rply && !(din || dout)) |=> !rply)
  else
  begin
    fail_count++;
    $error("rply held after the strobe dropped");
  end

  // Single write pulse per cycle
  we_single: assert property (@(posedge clka) disable iff (rst)
    we |=> !we)
  else
  begin
    fail_count++;
    $error("we high for two cycles in a row");
  end

endmodule

bind qbus_cycle_ctrl qbus_mem_sva sva0 (
  .clka  (clka),
  .rst   (rst),
  .sync  (sync),
  .din   (din),
  .dout  (dout),
  .hit   (hit),
  .rply  (rply),
  .we    (mem.we),
  .state (state)
);

// File: dv/qbus_mem_tb.sv
module qbus_mem_tb
  import qmem_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEED           = 71181;
  localparam int N_MIXED        = 400;
  // Ten cycles per mixed transaction, directed phases fit in the margin
  localparam int TIMEOUT_CYCLES = N_MIXED * 10 + 1000;

  logic      clka;
  logic      rst;
  logic      sync;
  logic      din;
  logic      dout;
  logic      wtbt;
  bus_addr_t addr;
  data_t     wdata;
  logic      rply;
  data_t     rdata;

  // Shadow copy of the RAM, unknown outside the preload
  data_t      shadow [MEM_WORDS];
  // Word indexes holding defined data
  word_addr_t known [$];
  data_t      exp_rdata;
  logic       read_pending;
  logic       rply_q;
  int         cycle_count;

  qbus_mem_top dut0 (
    .clka  (clka),
    .rst   (rst),
    .sync  (sync),
    .din   (din),
    .dout  (dout),
    .wtbt  (wtbt),
    .addr  (addr),
    .wdata (wdata),
    .rply  (rply),
    .rdata (rdata)
  );

  initial
  begin
    clka = 1'b0;
    forever #2 clka = ~clka;
  end

  // ----------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------

  // Word after a write, byte write touches lane addr[0] only
  function automatic data_t ref_write(data_t old, data_t wd, logic byte_wr, logic odd);
    data_t res;
    res = old;
    if (!byte_wr)
      res = wd;
    else if (odd)
      res[15:8] = wd[15:8];
    else
      res[7:0] = wd[7:0];
    return res;
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopped at first error");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "Stopped at first error");
    end
  endtask

  // Read data checked on the rising edge of rply
  always @(negedge clka)
  begin
    if (!rst && rply && !rply_q && read_pending)
      check_data("rdata", rdata, exp_rdata);
    rply_q <= rply;
  end

  // ----------------------------------------
  // Bus master
  // ----------------------------------------

  // One full cycle; stall holds the strobe after rply
  task automatic run_cycle(input bus_addr_t a, input logic is_write, input logic byte_wr,
                           input data_t wd, input int stall);
    @(negedge clka);
    addr = a;
    sync = 1'b1;
    // Control needs two edges to decode the window
    repeat (2) @(negedge clka);
    if (is_write)
    begin
      wdata = wd;
      wtbt  = byte_wr;
      dout  = 1'b1;
    end
    else
      din = 1'b1;
    do
      @(negedge clka);
    while (!rply);
    repeat (stall)
    begin
      @(negedge clka);
      check_bit("rply", rply, 1'b1);
      if (!is_write)
        check_data("rdata", rdata, exp_rdata);
    end
    din  = 1'b0;
    dout = 1'b0;
    do
      @(negedge clka);
    while (rply);
    sync = 1'b0;
    wtbt = 1'b0;
    @(negedge clka);
  endtask

  task automatic read_word(input word_addr_t idx, input int stall);
    exp_rdata    = shadow[idx];
    read_pending = 1'b1;
    run_cycle({2'b00, idx, 1'b0}, 1'b0, 1'b0, 16'h0000, stall);
    read_pending = 1'b0;
  endtask

  task automatic write_word(input word_addr_t idx, input data_t wd);
    run_cycle({2'b00, idx, 1'b0}, 1'b1, 1'b0, wd, 0);
    shadow[idx] = ref_write(shadow[idx], wd, 1'b0, 1'b0);
  endtask

  task automatic write_byte(input word_addr_t idx, input logic odd, input data_t wd);
    run_cycle({2'b00, idx, odd}, 1'b1, 1'b1, wd, 0);
    shadow[idx] = ref_write(shadow[idx], wd, 1'b1, odd);
  endtask

  // Out-of-window cycle, master gives up after 10 cycles
  task automatic abort_cycle(input bus_addr_t a, input logic is_write, input data_t wd);
    @(negedge clka);
    addr = a;
    sync = 1'b1;
    repeat (2) @(negedge clka);
    wdata = wd;
    dout  = is_write;
    din   = !is_write;
    repeat (10)
    begin
      @(negedge clka);
      check_bit("rply", rply, 1'b0);
    end
    din  = 1'b0;
    dout = 1'b0;
    sync = 1'b0;
    repeat (2) @(negedge clka);
  endtask

  // ----------------------------------------
  // Watchdogs
  // ----------------------------------------

  always @(posedge clka)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Hang: test still running after %0d clka cycles", cycle_count);
      $display("TEST FAIL");
      $fatal(1, "Timeout");
    end
  end

  // Any handshake assertion failure ends the run
  always @(negedge clka)
  begin
    if (dut0.u_ctrl.sva0.fail_count != 0)
    begin
      $display("A bus handshake assertion failed");
      $display("TEST FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial
  begin
    int         seed_out;
    word_addr_t idx;
    int         kind;

    seed_out     = $urandom(SEED);
    rst          = 1'b1;
    sync         = 1'b0;
    din          = 1'b0;
    dout         = 1'b0;
    wtbt         = 1'b0;
    addr         = '0;
    wdata        = '0;
    read_pending = 1'b0;
    rply_q       = 1'b0;
    cycle_count  = 0;
    $readmemh(MEM_INIT_FILE, shadow);
    // Preload words must all be defined
    for (int i = 0; i < 16; i++)
    begin
      if ($isunknown(shadow[i]))
      begin
        $display("Preload word %0d could not be read from the hex file", i);
        $display("TEST FAIL");
        $fatal(1, "Missing preload data");
      end
    end
    for (int i = 0; i < 16; i++)
      known.push_back(word_addr_t'(i));

    repeat (5) @(negedge clka);
    rst = 1'b0;
    @(negedge clka);
    check_bit("rply", rply, 1'b0);

    // Preload readback
    for (int i = 0; i < 16; i++)
      read_word(word_addr_t'(i), 0);

    // Word writes across the whole depth, then readback
    for (int i = 0; i < 20; i++)
    begin
      idx = word_addr_t'($urandom_range(MEM_WORDS - 1, 16));
      write_word(idx, data_t'($urandom()));
      known.push_back(idx);
    end
    for (int i = 16; i < known.size(); i++)
      read_word(known[i], 0);

    // Byte lanes, even then odd
    for (int i = 0; i < 16; i++)
    begin
      write_byte(known[i], i[0], data_t'($urandom()));
      read_word(known[i], 0);
    end

    // Outside the window, same word index must not change
    for (int i = 0; i < 4; i++)
    begin
      idx = known[$urandom_range(known.size() - 1)];
      abort_cycle({2'(i % 3 + 1), idx, 1'b0}, i[0], ~shadow[idx]);
      read_word(idx, 0);
    end

    // Master stalls on din, then a normal cycle
    read_word(known[3], 12);
    read_word(known[20], 0);

    // Mixed traffic
    for (int i = 0; i < N_MIXED; i++)
    begin
      kind = $urandom_range(2);
      idx  = known[$urandom_range(known.size() - 1)];
      if (kind == 0)
        read_word(idx, 0);
      else if (kind == 1)
      begin
        // Half the word writes open a fresh location
        if ($urandom_range(1) == 1)
        begin
          idx = word_addr_t'($urandom_range(MEM_WORDS - 1));
          known.push_back(idx);
        end
        write_word(idx, data_t'($urandom()));
      end
      else
        write_byte(idx, 1'($urandom_range(1)), data_t'($urandom()));
    end

    if (dut0.u_ctrl.sva0.fail_count == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("TEST FAIL");
      $fatal(1, "Checks failed");
    end
  end

endmodule

// File: list.f
src/qmem_pkg.sv
src/mem_if.sv
src/qbus_cycle_ctrl.sv
src/bus_latch.sv
src/word_ram.sv
src/qbus_mem_top.sv
dv/qbus_mem_sva.sv
dv/qbus_mem_tb.sv

// File: mem_init.hex
// One 16-bit word per line in hex, RAM words 0 to 15 in order
0a00
1b11
2c22
3d33
4e44
5f55
6066
7177
8288
9399
a4aa
b5bb
c6cc
d7dd
e8ee
f9ff
